/* hdl/spgd_cfg.svh */
// SPGD configuration: channel count, widths, wait counts and loop constants.
`ifndef SPGD_CFG_SVH
`define SPGD_CFG_SVH

// ----------------------------------------
// Sizes
// ----------------------------------------
`define SPGD_CHANNELS 4
`define SPGD_DAC_WIDTH 14
`define SPGD_ADDR_WIDTH 2
`define SPGD_METRIC_WIDTH 16
`define SPGD_COUNT_WIDTH 32

// ----------------------------------------
// Fixed waits, in ADC_CLK cycles
// ----------------------------------------
`define SPGD_MATH_TIME 10
`define SPGD_UPDATE_TIME 40
`define SPGD_RNG_TIME 8

// Loop constants.
`define SPGD_DELTA 64
`define SPGD_GAIN_SHIFT 4
`define SPGD_RNG_SEED 32'h2545_f491
`define SPGD_MID (1 << (`SPGD_DAC_WIDTH - 1))   // Half scale.

`endif

/* hdl/spgd_timing_pkg.sv */
// SPGD timing types: sequencer states and DAC phase select.
package spgd_timing_pkg;

	typedef enum logic [3:0]
	{
		stopped  = 4'b0000,
		settle_a = 4'b0001,
		adc_a    = 4'b0010,
		math_a   = 4'b0011,
		jp_wrt   = 4'b0100,
		settle_b = 4'b0101,
		adc_b    = 4'b0110,
		math_b   = 4'b0111,
		jm_wrt   = 4'b1000,
		math_c   = 4'b1001,
		u_wrt    = 4'b1010,
		rng_wait = 4'b1011,
		du_wrt   = 4'b1100,
		settle_c = 4'b1101
	} spgd_state_t;

	typedef enum logic [1:0]
	{
		phase_hold  = 2'b00,
		phase_plus  = 2'b01,
		phase_minus = 2'b10,
		phase_new   = 2'b11
	} dac_phase_t;

endpackage

/* hdl/spgd_data_pkg.sv */
// SPGD data types: actuator word, metric sample and signed step.
package spgd_data_pkg;

	`include "spgd_cfg.svh"

	// Unsigned DAC code.
	typedef logic [`SPGD_DAC_WIDTH-1:0] act_word_t;

	// Raw ADC sample of the quality metric.
	typedef logic [`SPGD_METRIC_WIDTH-1:0] metric_t;

	// J+ minus J-, one extra bit for the sign.
	typedef logic signed [`SPGD_METRIC_WIDTH:0] step_t;

endpackage

/* hdl/spgd_sequencer.sv */
// SPGD sequencer: iteration FSM with one reloadable wait counter and two timing modes.
`timescale 1ns/1ps
`include "spgd_cfg.svh"

module spgd_sequencer
	import spgd_timing_pkg::*;
(
	input  logic                         ADC_CLK,
	input  logic                         rst,
	input  logic                         fsm_en,
	input  logic                         mode,
	input  logic                         ext_trig,
	input  logic                         adc_done,
	input  logic [`SPGD_COUNT_WIDTH-1:0] j_time,
	output logic                         adc_en,
	output logic                         reg_rst,
	output logic                         rng_step,
	output logic                         j_p_wrt,
	output logic                         j_m_wrt,
	output logic                         u_wrt,
	output logic                         du_wrt,
	output dac_phase_t                   dac_phase,
	output spgd_state_t                  fsm_state
);

	localparam int CW = `SPGD_COUNT_WIDTH;

	spgd_state_t state;
	spgd_state_t next_state;
	logic [CW-1:0] cnt;
	logic [CW-1:0] wait_val;
	logic timer_done;
	logic settle_done;

	assign fsm_state = state;
	assign timer_done = (cnt <= CW'(1));
	assign settle_done = mode ? ext_trig : timer_done;   // Mode 1 waits on the trigger.

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			stopped:                 next_state = settle_a;
			settle_a:                if (settle_done) next_state = adc_a;
			adc_a:                   if (adc_done) next_state = math_a;
			math_a:                  if (timer_done) next_state = jp_wrt;
			jp_wrt:                  next_state = settle_b;
			settle_b:                if (settle_done) next_state = adc_b;
			adc_b:                   if (adc_done) next_state = math_b;
			math_b:                  if (timer_done) next_state = jm_wrt;
			jm_wrt:                  next_state = math_c;
			math_c:                  if (timer_done) next_state = spgd_timing_pkg::u_wrt;
			spgd_timing_pkg::u_wrt:  next_state = rng_wait;
			rng_wait:                if (timer_done) next_state = spgd_timing_pkg::du_wrt;
			spgd_timing_pkg::du_wrt: next_state = settle_c;
			settle_c:                if (timer_done) next_state = settle_a;
			default:                 next_state = stopped;
		endcase
		if (!fsm_en)
			next_state = stopped;
	end

	// Wait length of the state being entered.
	always_comb
	begin
		case (next_state)
			settle_a, settle_b: wait_val = j_time;
			settle_c:           wait_val = mode ? CW'(1) : {j_time[CW-2:0], 1'b0};
			math_a, math_b:     wait_val = CW'(`SPGD_MATH_TIME);
			math_c:             wait_val = CW'(`SPGD_UPDATE_TIME);
			rng_wait:           wait_val = CW'(`SPGD_RNG_TIME);
			default:            wait_val = CW'(1);
		endcase
	end

	always_ff @(posedge ADC_CLK)
	begin
		if (rst)
		begin
			state <= stopped;
			cnt <= '0;
		end
		else
		begin
			state <= next_state;
			if (next_state != state)
				cnt <= wait_val;   // Reload on entry.
			else if (cnt != '0)
				cnt <= cnt - CW'(1);
		end
	end

	// ----------------------------------------
	// Registered state decodes
	// ----------------------------------------
	always_ff @(posedge ADC_CLK)
	begin
		if (rst)
		begin
			adc_en <= 1'b0;
			reg_rst <= 1'b1;
			rng_step <= 1'b0;
			j_p_wrt <= 1'b0;
			j_m_wrt <= 1'b0;
			u_wrt <= 1'b0;
			du_wrt <= 1'b0;
			dac_phase <= phase_hold;
		end
		else
		begin
			adc_en <= state inside {adc_a, math_a, jp_wrt, adc_b, math_b, jm_wrt};
			reg_rst <= (state == stopped);
			rng_step <= (state == rng_wait);
			j_p_wrt <= (state == jp_wrt);
			j_m_wrt <= (state == jm_wrt);
			u_wrt <= (state == spgd_timing_pkg::u_wrt);
			du_wrt <= (state == spgd_timing_pkg::du_wrt);
			case (state)
				settle_a, adc_a, math_a, jp_wrt:
					dac_phase <= phase_plus;
				settle_b, adc_b, math_b, jm_wrt, math_c, spgd_timing_pkg::u_wrt:
					dac_phase <= phase_minus;
				rng_wait, spgd_timing_pkg::du_wrt, settle_c:
					dac_phase <= phase_new;
				default:
					dac_phase <= phase_hold;
			endcase
		end
	end

endmodule

/* hdl/perturb_gen.sv */
// Perturbation generator: xorshift32 source of the per-channel sign vector.
`timescale 1ns/1ps
`include "spgd_cfg.svh"

module perturb_gen
(
	input  logic                      ADC_CLK,
	input  logic                      rst,
	input  logic                      rng_step,
	input  logic                      du_wrt,
	output logic [`SPGD_CHANNELS-1:0] signs   // 1 means s = -1.
);

	localparam int N = `SPGD_CHANNELS;
	localparam logic [31:0] SEED = `SPGD_RNG_SEED;

	logic [31:0] x;

	function automatic logic [31:0] xorshift32(input logic [31:0] v);
		logic [31:0] t;
		t = v ^ (v << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	always_ff @(posedge ADC_CLK)
	begin
		if (rst)
		begin
			x <= SEED;
			signs <= SEED[N-1:0];
		end
		else
		begin
			if (rng_step)
				x <= xorshift32(x);
			if (du_wrt)
				signs <= x[N-1:0];   // Held for the whole iteration.
		end
	end

endmodule

/* hdl/gradient_estimator.sv */
// Gradient estimator: latches J+ and J- and forms the gain-scaled signed step.
`timescale 1ns/1ps
`include "spgd_cfg.svh"

module gradient_estimator
	import spgd_data_pkg::*;
(
	input  logic    ADC_CLK,
	input  logic    rst,
	input  logic    reg_rst,
	input  metric_t adc_data,
	input  logic    j_p_wrt,
	input  logic    j_m_wrt,
	output step_t   step
);

	metric_t j_plus;
	metric_t j_minus;
	step_t   diff;
	logic    calc_q;

	assign diff = $signed({1'b0, j_plus}) - $signed({1'b0, j_minus});

	always_ff @(posedge ADC_CLK)
	begin
		if (rst || reg_rst)
		begin
			j_plus <= '0;
			j_minus <= '0;
			calc_q <= 1'b0;
			step <= '0;
		end
		else
		begin
			if (j_p_wrt)
				j_plus <= adc_data;
			if (j_m_wrt)
				j_minus <= adc_data;
			calc_q <= j_m_wrt;   // J- is valid one cycle later.
			if (calc_q)
				step <= diff >>> `SPGD_GAIN_SHIFT;
		end
	end

endmodule

/* hdl/spgd_channel.sv */
// Actuator channel: holds u with saturating update and drives the phase word.
`timescale 1ns/1ps
`include "spgd_cfg.svh"

module spgd_channel
	import spgd_timing_pkg::*, spgd_data_pkg::*;
(
	input  logic       ADC_CLK,
	input  logic       rst,
	input  logic       sign,
	input  step_t      step,
	input  logic       u_wrt,
	input  dac_phase_t dac_phase,
	output act_word_t  dac_word
);

	localparam int DW = `SPGD_DAC_WIDTH;
	localparam int STW = $bits(step_t);
	localparam int SW = `SPGD_METRIC_WIDTH + 3;   // Room for u plus or minus a full step.
	localparam logic signed [SW-1:0] FULL = (1 << DW) - 1;
	localparam logic signed [SW-1:0] DELTA = `SPGD_DELTA;

	act_word_t u;
	logic signed [SW-1:0] u_ext;
	logic signed [SW-1:0] step_ext;
	logic signed [SW-1:0] u_next;

	function automatic act_word_t clamp_word(input logic signed [SW-1:0] v);
		if (v < 0)
			return '0;
		if (v > FULL)
			return '1;
		return v[DW-1:0];
	endfunction

	assign u_ext = $signed({{(SW-DW){1'b0}}, u});
	assign step_ext = {{(SW-STW){step[STW-1]}}, step};
	assign u_next = sign ? u_ext - step_ext : u_ext + step_ext;

	always_ff @(posedge ADC_CLK)
	begin
		if (rst)
			u <= act_word_t'(`SPGD_MID);
		else if (u_wrt)
			u <= clamp_word(u_next);
	end

	always_ff @(posedge ADC_CLK)
	begin
		case (dac_phase)
			phase_plus:  dac_word <= clamp_word(sign ? u_ext - DELTA : u_ext + DELTA);
			phase_minus: dac_word <= clamp_word(sign ? u_ext + DELTA : u_ext - DELTA);
			default:     dac_word <= u;   // Plain u.
		endcase
	end

endmodule

/* hdl/dac_serializer.sv */
// DAC serializer: snapshots all channel words on a phase change and shifts one frame.
`timescale 1ns/1ps
`include "spgd_cfg.svh"

module dac_serializer
	import spgd_timing_pkg::*;
(
	input  logic                                         ADC_CLK,
	input  logic                                         rst,
	input  dac_phase_t                                   dac_phase,
	input  logic [`SPGD_CHANNELS*`SPGD_DAC_WIDTH-1:0]    words,
	output logic                                         dac_sync,
	output logic                                         dac_sdata
);

	localparam int N = `SPGD_CHANNELS;
	localparam int DW = `SPGD_DAC_WIDTH;
	localparam int AW = `SPGD_ADDR_WIDTH;
	localparam int WW = AW + DW;
	localparam int FW = N * WW;
	localparam int BW = $clog2(FW);

	dac_phase_t phase_q;
	logic change_q;
	logic busy;
	logic pending;
	logic start;
	logic [BW-1:0] bits_left;
	logic [FW-1:0] frame;
	logic [FW-1:0] shreg;

	// Channel 0 first, address above value.
	always_comb
	begin
		for (int i = 0; i < N; i++)
			frame[FW-1-i*WW -: WW] = {AW'(i), words[i*DW +: DW]};
	end

	// Channel words follow the phase by one cycle, hence the delayed flag.
	assign start = !busy && (change_q || pending);

	always_ff @(posedge ADC_CLK)
	begin
		if (rst)
		begin
			phase_q <= phase_hold;
			change_q <= 1'b0;
			busy <= 1'b0;
			pending <= 1'b0;
			bits_left <= '0;
			dac_sync <= 1'b1;
			dac_sdata <= 1'b0;
		end
		else
		begin
			phase_q <= dac_phase;
			change_q <= (dac_phase != phase_q);
			if (start)
			begin
				busy <= 1'b1;
				pending <= 1'b0;
				dac_sync <= 1'b0;
				dac_sdata <= frame[FW-1];
				bits_left <= BW'(FW - 1);
			end
			else if (busy)
			begin
				if (change_q)
					pending <= 1'b1;   // Resend after this frame.
				if (bits_left == '0)
				begin
					busy <= 1'b0;
					dac_sync <= 1'b1;
					dac_sdata <= 1'b0;
				end
				else
				begin
					dac_sdata <= shreg[FW-1];
					bits_left <= bits_left - BW'(1);
				end
			end
		end
	end

	always_ff @(posedge ADC_CLK)
	begin
		if (start)
			shreg <= frame << 1;
		else if (busy)
			shreg <= shreg << 1;
	end

endmodule

/* hdl/spgd_top.sv */
// SPGD core top: sequencer, sign and step feeders, channel array and DAC serializer.
`timescale 1ns/1ps
`include "spgd_cfg.svh"

module spgd_top
	import spgd_timing_pkg::*, spgd_data_pkg::*;
(
	input  logic                         ADC_CLK,
	input  logic                         rst,
	input  logic                         fsm_en,
	input  logic                         mode,
	input  logic                         ext_trig,
	input  logic                         adc_done,
	input  metric_t                      adc_data,
	input  logic [`SPGD_COUNT_WIDTH-1:0] j_time,
	output logic                         adc_en,
	output spgd_state_t                  fsm_state,
	output logic                         dac_sync,
	output logic                         dac_sdata
);

	localparam int N = `SPGD_CHANNELS;
	localparam int DW = `SPGD_DAC_WIDTH;

	logic reg_rst;
	logic rng_step;
	logic j_p_wrt;
	logic j_m_wrt;
	logic u_wrt;
	logic du_wrt;
	dac_phase_t dac_phase;
	logic [N-1:0] signs;
	step_t step;
	logic [N*DW-1:0] words;

	spgd_sequencer u_sequencer (
		.ADC_CLK   (ADC_CLK),
		.rst       (rst),
		.fsm_en    (fsm_en),
		.mode      (mode),
		.ext_trig  (ext_trig),
		.adc_done  (adc_done),
		.j_time    (j_time),
		.adc_en    (adc_en),
		.reg_rst   (reg_rst),
		.rng_step  (rng_step),
		.j_p_wrt   (j_p_wrt),
		.j_m_wrt   (j_m_wrt),
		.u_wrt     (u_wrt),
		.du_wrt    (du_wrt),
		.dac_phase (dac_phase),
		.fsm_state (fsm_state)
	);

	perturb_gen u_perturb_gen (
		.ADC_CLK  (ADC_CLK),
		.rst      (rst),
		.rng_step (rng_step),
		.du_wrt   (du_wrt),
		.signs    (signs)
	);

	gradient_estimator u_gradient_estimator (
		.ADC_CLK  (ADC_CLK),
		.rst      (rst),
		.reg_rst  (reg_rst),
		.adc_data (adc_data),
		.j_p_wrt  (j_p_wrt),
		.j_m_wrt  (j_m_wrt),
		.step     (step)
	);

	// ----------------------------------------
	// Channel array
	// ----------------------------------------
	for (genvar i = 0; i < N; i++)
	begin : g_chan
		spgd_channel u_chan (
			.ADC_CLK   (ADC_CLK),
			.rst       (rst),
			.sign      (signs[i]),
			.step      (step),
			.u_wrt     (u_wrt),
			.dac_phase (dac_phase),
			.dac_word  (words[i*DW +: DW])
		);
	end

	dac_serializer u_dac_serializer (
		.ADC_CLK   (ADC_CLK),
		.rst       (rst),
		.dac_phase (dac_phase),
		.words     (words),
		.dac_sync  (dac_sync),
		.dac_sdata (dac_sdata)
	);

endmodule

/* bench/tb_spgd_top.sv */
// SPGD core testbench with ADC and trigger model, DAC frame decoder, reference model and checks.
`timescale 1ns/1ps
`include "spgd_cfg.svh"

module tb_spgd_top
	import spgd_timing_pkg::*;
();

	localparam int N = `SPGD_CHANNELS;
	localparam int DW = `SPGD_DAC_WIDTH;
	localparam int AW = `SPGD_ADDR_WIDTH;
	localparam int WW = AW + DW;
	localparam int FW = N * WW;
	localparam int FULL = (1 << DW) - 1;
	localparam int JT = 64;

	logic ADC_CLK = 1'b0;
	logic rst = 1'b1;
	logic fsm_en;
	logic mode;
	logic ext_trig;
	logic adc_done = 1'b0;
	logic [`SPGD_METRIC_WIDTH-1:0] adc_data = '0;
	logic [`SPGD_COUNT_WIDTH-1:0] j_time;
	logic adc_en;
	spgd_state_t fsm_state;
	logic dac_sync;
	logic dac_sdata;

	// Reference model and bench state.
	int u_m [N];
	logic [31:0] x_m;
	logic [N-1:0] signs_m;
	int jp_s;
	int jm_s;
	logic [31:0] rnd = 32'd89;
	int iters_done;
	int frame_idx;
	int word0_new;
	bit frames_on;
	bit forcing;
	bit push_down;
	int errors;
	int adc_wait;
	bit adc_en_q;
	bit for_plus;
	logic [FW-1:0] frame_sh;
	int nbits;

	spgd_top u_spgd_top (
		.ADC_CLK   (ADC_CLK),
		.rst       (rst),
		.fsm_en    (fsm_en),
		.mode      (mode),
		.ext_trig  (ext_trig),
		.adc_done  (adc_done),
		.adc_data  (adc_data),
		.j_time    (j_time),
		.adc_en    (adc_en),
		.fsm_state (fsm_state),
		.dac_sync  (dac_sync),
		.dac_sdata (dac_sdata)
	);

	initial
	begin
		forever #2 ADC_CLK = ~ADC_CLK;
	end

	function automatic logic [31:0] next_xorshift(input logic [31:0] v);
		logic [31:0] t;
		t = v ^ (v << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	function automatic int fit_dac(input int v);
		if (v < 0)
			return 0;
		if (v > FULL)
			return FULL;
		return v;
	endfunction

	// Expected mode 0 state length or zero where it varies.
	function automatic int fixed_len(input spgd_state_t s);
		case (s)
			settle_a, settle_b: return JT;
			settle_c:           return 2 * JT;
			math_a, math_b:     return `SPGD_MATH_TIME;
			math_c:             return `SPGD_UPDATE_TIME;
			rng_wait:           return `SPGD_RNG_TIME;
			adc_a, adc_b, stopped: return 0;
			default:            return 1;
		endcase
	endfunction

	task automatic fail_run();
		errors++;
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic hold_reset();
		rst = 1'b1;
		repeat (5) @(negedge ADC_CLK);
		rst = 1'b0;
	endtask

	task automatic wait_state(input spgd_state_t s, input int limit);
		int n;
		n = 0;
		while (fsm_state != s)
		begin
			@(negedge ADC_CLK);
			n++;
			if (n > limit)
			begin
				$display("Timeout waiting for state %s", s.name());
				fail_run();
			end
		end
	endtask

	// Waits out the current state, checks its length and the state that follows.
	task automatic follow_state(input spgd_state_t exp, input int limit);
		spgd_state_t cur;
		int len;
		cur = fsm_state;
		len = 0;
		while (fsm_state == cur)
		begin
			@(negedge ADC_CLK);
			len++;
			if (len > limit)
			begin
				$display("Timeout leaving state %s", cur.name());
				fail_run();
			end
		end
		check_value("fsm_state", fsm_state, exp);
		if (fixed_len(cur) != 0)
			check_value($sformatf("%s cycles", cur.name()), len, fixed_len(cur));
	endtask

	task automatic walk_iteration();
		spgd_state_t order [13];
		order = '{adc_a, math_a, jp_wrt, settle_b, adc_b, math_b, jm_wrt, math_c,
			u_wrt, rng_wait, du_wrt, settle_c, settle_a};
		for (int i = 0; i < 13; i++)
		begin
			follow_state(order[i], 300);
			if (i == 0)
			begin
				check_value("adc_en", adc_en, 0);
				@(negedge ADC_CLK);
				check_value("adc_en", adc_en, 1);   // j_time+1 after settle_a entry.
			end
		end
	endtask

	task automatic wait_iters(input int target, input int limit);
		int n;
		n = 0;
		while (iters_done < target)
		begin
			@(negedge ADC_CLK);
			n++;
			if (n > limit)
			begin
				$display("Timeout waiting for iteration %0d to finish", target);
				fail_run();
			end
		end
	endtask

	task automatic wait_sync(input logic level, input int limit);
		int n;
		n = 0;
		while (dac_sync != level)
		begin
			@(negedge ADC_CLK);
			n++;
			if (n > limit)
			begin
				$display("Timeout waiting for dac_sync to reach %0d", level);
				fail_run();
			end
		end
	endtask

	task automatic check_stopped(input int cycles);
		repeat (cycles)
		begin
			@(negedge ADC_CLK);
			check_value("fsm_state", fsm_state, stopped);
			check_value("adc_en", adc_en, 0);
			check_value("dac_sync", dac_sync, 1);
		end
	endtask

	// Holds a settle state past the mode 0 timer length, then expects the exit one cycle
	// after the trigger.
	task automatic trigger_settle(input spgd_state_t s, input spgd_state_t after, input int limit);
		wait_state(s, limit);
		repeat (JT + 20)
		begin
			@(negedge ADC_CLK);
			check_value("fsm_state", fsm_state, s);
		end
		ext_trig = 1'b1;
		@(negedge ADC_CLK);
		ext_trig = 1'b0;
		check_value("fsm_state", fsm_state, after);
	endtask

	task automatic check_frame();
		int kind;
		int step;
		int sgn;
		int addr;
		int val;
		int expv;
		kind = frame_idx % 3;   // Plus, minus, new.
		step = (jp_s - jm_s) >>> `SPGD_GAIN_SHIFT;
		for (int i = 0; i < N; i++)
		begin
			addr = int'(frame_sh[FW-1-WW*i -: AW]);
			val = int'(frame_sh[FW-1-WW*i-AW -: DW]);
			sgn = signs_m[i] ? -1 : 1;
			if (kind == 0)
				expv = fit_dac(u_m[i] + sgn * `SPGD_DELTA);
			else if (kind == 1)
				expv = fit_dac(u_m[i] - sgn * `SPGD_DELTA);
			else
			begin
				u_m[i] = fit_dac(u_m[i] + sgn * step);
				expv = u_m[i];
			end
			check_value("dac_sdata address", addr, i);
			check_value($sformatf("dac_sdata word %0d", i), val, expv);
			if (i == 0)
				word0_new = val;
		end
		if (kind == 2)
		begin
			repeat (`SPGD_RNG_TIME) x_m = next_xorshift(x_m);
			signs_m = x_m[N-1:0];   // Signs for the next iteration.
			iters_done++;
		end
		frame_idx++;
	endtask

	// ----------------------------------------
	// ADC model
	// ----------------------------------------
	always @(negedge ADC_CLK)
	begin
		if (rst)
		begin
			adc_wait = 0;
			adc_en_q = 1'b0;
			adc_done = 1'b0;
		end
		else
		begin
			adc_done = 1'b0;
			if (adc_wait > 0)
			begin
				adc_wait--;
				if (adc_wait == 0)
				begin
					rnd = next_xorshift(rnd);
					if (forcing)
						adc_data = ((signs_m[0] ^ push_down) ^ !for_plus) ? 16'h0000 : 16'hffff;
					else
						adc_data = rnd[15:0];
					if (for_plus)
						jp_s = int'(adc_data);
					else
						jm_s = int'(adc_data);
					adc_done = 1'b1;
				end
			end
			if (adc_en && !adc_en_q)
			begin
				rnd = next_xorshift(rnd);
				adc_wait = 3 + int'(rnd[2:0]);   // 3 to 10 cycles.
				for_plus = (fsm_state == adc_a);
			end
			adc_en_q = adc_en;
		end
	end

	// ----------------------------------------
	// Frame decoder
	// ----------------------------------------
	always @(negedge ADC_CLK)
	begin
		if (rst)
		begin
			nbits = 0;
			frame_idx = 0;
			iters_done = 0;
			x_m = `SPGD_RNG_SEED;
			signs_m = x_m[N-1:0];
			for (int i = 0; i < N; i++)
				u_m[i] = `SPGD_MID;
		end
		else if (dac_sync)
			nbits = 0;
		else
		begin
			frame_sh = {frame_sh[FW-2:0], dac_sdata};
			nbits++;
			if (nbits == FW)
			begin
				nbits = 0;
				if (frames_on)
					check_frame();
			end
		end
	end

	initial
	begin
		fsm_en = 1'b0;
		mode = 1'b0;
		ext_trig = 1'b0;
		j_time = `SPGD_COUNT_WIDTH'(JT);
		frames_on = 1'b0;
		forcing = 1'b0;
		push_down = 1'b0;
		errors = 0;
		hold_reset();
		check_stopped(10);

		// Mode 0 with random metric samples.
		frames_on = 1'b1;
		fsm_en = 1'b1;
		wait_state(settle_a, 5);
		walk_iteration();
		wait_iters(3, 1000);

		// Drive channel 0 to full scale, then to zero.
		forcing = 1'b1;
		for (int k = 4; k <= 15; k++)
		begin
			push_down = (k >= 10);
			wait_iters(k, 1000);
			if (k == 8 || k == 9)
				check_value("dac_sdata word 0", word0_new, FULL);
			if (k == 14 || k == 15)
				check_value("dac_sdata word 0", word0_new, 0);
		end

		frames_on = 1'b0;
		fsm_en = 1'b0;
		wait_state(stopped, 5);
		wait_sync(1'b0, 20);    // Hold frame.
		wait_sync(1'b1, 100);
		check_stopped(20);

		// ----------------------------------------
		// Mode 1 with external trigger
		// ----------------------------------------
		forcing = 1'b0;
		mode = 1'b1;
		hold_reset();
		fsm_en = 1'b1;
		trigger_settle(settle_a, adc_a, 5);
		trigger_settle(settle_b, adc_b, 200);
		trigger_settle(settle_a, adc_a, 300);
		fsm_en = 1'b0;
		wait_state(stopped, 5);

		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+hdl
hdl/spgd_timing_pkg.sv
hdl/spgd_data_pkg.sv
hdl/spgd_sequencer.sv
hdl/perturb_gen.sv
hdl/gradient_estimator.sv
hdl/spgd_channel.sv
hdl/dac_serializer.sv
hdl/spgd_top.sv
bench/tb_spgd_top.sv

/* Makefile */
# Verilator flow for the SPGD core.

VERILATOR  ?= verilator
TOP        ?= tb_spgd_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation passed
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
